//--- ciExtension_defs.svh
// Custom instruction numbers, reset counter width, profiling counter count, gray weights
`ifndef CI_EXTENSION_DEFS_SVH
`define CI_EXTENSION_DEFS_SVH

// Custom instruction numbers seen on ciN
`define CI_ID_SWAP    8'h01
`define CI_ID_PROFILE 8'h0B
`define CI_ID_GRAY    8'h0C

// Release happens when the top bit sets, 16 cycles after lock
`define RESET_COUNT_BITS 5

// Total, stall, bus idle and busy cycles
`define PROFILE_COUNTERS 4

// Luma weights, scaled so they sum to 256
`define GRAY_WEIGHT_RED   8'd54
`define GRAY_WEIGHT_GREEN 8'd183
`define GRAY_WEIGHT_BLUE  8'd19

`endif

//--- ciExtensionPkg.sv
// Package ciExtensionPkg with the custom-instruction and profiling typedefs
`default_nettype none

`include "ciExtension_defs.svh"

package ciExtensionPkg;

  // Custom instruction number
  typedef logic [7:0] ciOpcode_t;

  // Operand and result word
  typedef logic [31:0] ciWord_t;

  // Profiling counter
  typedef logic [31:0] counterValue_t;
  typedef logic [`PROFILE_COUNTERS-1:0] counterMask_t;
  typedef logic [$clog2(`PROFILE_COUNTERS)-1:0] counterSelect_t;

endpackage

`default_nettype wire

//--- resetSequencer.sv
// Module resetSequencer, CPU and camera reset release after PLL lock
`timescale 1ns/1ps
`default_nettype none

`include "ciExtension_defs.svh"

module resetSequencer (
  input  wire  s_systemClock,
  input  wire  s_pllLocked,
  output logic cpuReset,
  output logic camnReset
);

  logic [`RESET_COUNT_BITS-1:0] resetCount;

  // Counter saturates once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_BITS-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign camnReset = resetCount[`RESET_COUNT_BITS-1];
  assign cpuReset  = ~resetCount[`RESET_COUNT_BITS-1];

  // Camera stays out of reset as long as the PLL holds lock
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    camnReset |=> camnReset);

endmodule

`default_nettype wire

//--- swapByteIse.sv
// Module swapByteIse, byte reversal and halfword byte swap instruction
`timescale 1ns/1ps
`default_nettype none

`include "ciExtension_defs.svh"

module swapByteIse
  import ciExtensionPkg::*;
(
  input  wire ciOpcode_t ciN,
  input  wire ciWord_t   ciDataA,
  input  wire ciWord_t   ciDataB,
  input  wire            ciStart,
  output logic           ciDone,
  output ciWord_t        ciResult
);

  ciWord_t swappedWord;

  // Bit 0 of B picks halfword swap over full reversal
  always_comb begin
    if (ciDataB[0]) begin
      swappedWord = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
    end else begin
      swappedWord = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  assign ciDone   = ciStart && (ciN == `CI_ID_SWAP);
  assign ciResult = ciDone ? swappedWord : '0;

endmodule

`default_nettype wire

//--- grayscaleIse.sv
// Module grayscaleIse, RGB565 pixel to 8-bit gray instruction
`timescale 1ns/1ps
`default_nettype none

`include "ciExtension_defs.svh"

module grayscaleIse
  import ciExtensionPkg::*;
(
  input  wire ciOpcode_t ciN,
  input  wire ciWord_t   ciDataA,
  input  wire            ciStart,
  output logic           ciDone,
  output ciWord_t        ciResult
);

  logic [7:0]  redWide;
  logic [7:0]  greenWide;
  logic [7:0]  blueWide;
  logic [15:0] weightedSum;

  // Widen each field by repeating its top bits
  assign redWide   = {ciDataA[15:11], ciDataA[15:13]};
  assign greenWide = {ciDataA[10:5], ciDataA[10:9]};
  assign blueWide  = {ciDataA[4:0], ciDataA[4:2]};

  // Weights sum to 256 so white stays at 255
  assign weightedSum = 16'(`GRAY_WEIGHT_RED) * 16'(redWide)
                     + 16'(`GRAY_WEIGHT_GREEN) * 16'(greenWide)
                     + 16'(`GRAY_WEIGHT_BLUE) * 16'(blueWide);

  assign ciDone   = ciStart && (ciN == `CI_ID_GRAY);
  assign ciResult = ciDone ? {24'd0, weightedSum[15:8]} : '0;

endmodule

`default_nettype wire

//--- profileControl.sv
// Module profileControl, profiling instruction decode and counter enable register
`timescale 1ns/1ps
`default_nettype none

`include "ciExtension_defs.svh"

module profileControl
  import ciExtensionPkg::*;
(
  input  wire                s_systemClock,
  input  wire                s_pllLocked,
  input  wire                cpuReset,
  input  wire ciOpcode_t     ciN,
  input  wire ciWord_t       ciDataB,
  input  wire                ciStart,
  input  wire counterValue_t counterValue,
  output logic               ciDone,
  output ciWord_t            ciResult,
  output counterMask_t       counterEnable,
  output counterMask_t       counterClear
);

  counterMask_t enableSet;
  counterMask_t enableReset;

  // B fields: set enables, clear enables, clear counters
  assign enableSet    = ciDataB[3:0];
  assign enableReset  = ciDataB[7:4];

  // Commands are ignored while the CPU is held in reset
  assign ciDone       = ciStart && (ciN == `CI_ID_PROFILE) && !cpuReset;
  assign ciResult     = ciDone ? counterValue : '0;
  assign counterClear = ciDone ? ciDataB[11:8] : '0;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counterEnable <= '0;
    end else if (cpuReset) begin
      counterEnable <= '0;
    end else if (ciDone) begin
      // Set wins over clear
      counterEnable <= (counterEnable & ~enableReset) | enableSet;
    end
  end

  // Every enable named in the set field is on after the command
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    ciDone |=> ((counterEnable & $past(enableSet)) == $past(enableSet)));

endmodule

`default_nettype wire

//--- profileCounters.sv
// Module profileCounters, cycle, stall, bus-idle and busy counters with read select
`timescale 1ns/1ps
`default_nettype none

`include "ciExtension_defs.svh"

module profileCounters
  import ciExtensionPkg::*;
(
  input  wire                 s_systemClock,
  input  wire                 s_pllLocked,
  input  wire                 cpuReset,
  input  wire                 cpuIsStalled,
  input  wire                 busIdle,
  input  wire counterMask_t   counterEnable,
  input  wire counterMask_t   counterClear,
  input  wire counterSelect_t counterSelect,
  output counterValue_t       counterValue
);

  counterValue_t counters [`PROFILE_COUNTERS];
  counterMask_t  counterEvent;

  // Events for counters 3 down to 0
  assign counterEvent = {~cpuIsStalled & ~busIdle, busIdle, cpuIsStalled, 1'b1};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        // Clear takes priority over counting
        if (cpuReset || counterClear[i]) begin
          counters[i] <= '0;
        end else if (counterEnable[i] && counterEvent[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  assign counterValue = counters[counterSelect];

  for (genvar g = 0; g < `PROFILE_COUNTERS; g++) begin : gClearCheck
    assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
      cpuReset |=> (counters[g] == '0));
  end

endmodule

`default_nettype wire

//--- customInstructionFabric.sv
// Module customInstructionFabric, reset sequencer and custom instruction units with OR answer
`timescale 1ns/1ps
`default_nettype none

module customInstructionFabric
  import ciExtensionPkg::*;
(
  input  wire            s_systemClock,
  input  wire            s_pllLocked,
  input  wire ciOpcode_t ciN,
  input  wire ciWord_t   ciDataA,
  input  wire ciWord_t   ciDataB,
  input  wire            ciStart,
  input  wire            cpuIsStalled,
  input  wire            busIdle,
  output logic           ciDone,
  output ciWord_t        ciResult,
  output logic           camnReset
);

  logic           cpuReset;
  logic           swapDone;
  logic           grayDone;
  logic           profileDone;
  ciWord_t        swapResult;
  ciWord_t        grayResult;
  ciWord_t        profileResult;
  counterMask_t   counterEnable;
  counterMask_t   counterClear;
  counterSelect_t counterSelect;
  counterValue_t  counterValue;

  resetSequencer resetSeq0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset),
    .camnReset(camnReset)
  );

  swapByteIse swapByte0 (
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciStart(ciStart),
    .ciDone(swapDone),
    .ciResult(swapResult)
  );

  grayscaleIse gray0 (
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciStart(ciStart),
    .ciDone(grayDone),
    .ciResult(grayResult)
  );

  profileControl profileCtrl0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset),
    .ciN(ciN),
    .ciDataB(ciDataB),
    .ciStart(ciStart),
    .counterValue(counterValue),
    .ciDone(profileDone),
    .ciResult(profileResult),
    .counterEnable(counterEnable),
    .counterClear(counterClear)
  );

  // Counter index comes from operand A
  assign counterSelect = ciDataA[1:0];

  profileCounters counters0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset),
    .cpuIsStalled(cpuIsStalled),
    .busIdle(busIdle),
    .counterEnable(counterEnable),
    .counterClear(counterClear),
    .counterSelect(counterSelect),
    .counterValue(counterValue)
  );

  // Idle units drive zero, so the answers simply OR together
  assign ciDone   = swapDone | grayDone | profileDone;
  assign ciResult = swapResult | grayResult | profileResult;

endmodule

`default_nettype wire

//--- tbCustomInstructionFabric.sv
// Testbench tbCustomInstructionFabric with reset check, pattern replay, random swap and gray checks
`timescale 1ns/1ps
`default_nettype none

`include "ciExtension_defs.svh"

module tbCustomInstructionFabric
  import ciExtensionPkg::*;
();

  localparam int patternCount = 28;
  localparam int patternWords = 8;
  localparam int randomCount  = 400;
  localparam int clockPeriod  = 8;
  localparam int timeoutNs    = (patternCount + randomCount + 100) * clockPeriod;

  logic      s_systemClock;
  logic      s_pllLocked;
  ciOpcode_t ciN;
  ciWord_t   ciDataA;
  ciWord_t   ciDataB;
  logic      ciStart;
  logic      cpuIsStalled;
  logic      busIdle;
  logic      ciDone;
  ciWord_t   ciResult;
  logic      camnReset;

  logic [31:0] patternMem [patternCount*patternWords];
  logic [31:0] randomState;
  int          errorCount;
  int          checkCount;

  customInstructionFabric dut0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciStart(ciStart),
    .cpuIsStalled(cpuIsStalled),
    .busIdle(busIdle),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .camnReset(camnReset)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(clockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte k of the result comes from byte k^3 (reversal) or k^1 (halfword swap)
  function automatic ciWord_t expectedSwap(input ciWord_t operand, input logic halfword);
    ciWord_t result;
    int      k;
    int      source;
    for (k = 0; k < 4; k++) begin
      source = halfword ? (k ^ 1) : (k ^ 3);
      result[8*k +: 8] = operand[8*source +: 8];
    end
    return result;
  endfunction

  function automatic ciWord_t expectedGray(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    int sum;
    red   = int'(pixel[15:11]);
    green = int'(pixel[10:5]);
    blue  = int'(pixel[4:0]);
    red   = red * 8 + red / 4;
    green = green * 4 + green / 16;
    blue  = blue * 8 + blue / 4;
    sum   = int'(`GRAY_WEIGHT_RED) * red + int'(`GRAY_WEIGHT_GREEN) * green
          + int'(`GRAY_WEIGHT_BLUE) * blue;
    return ciWord_t'(sum / 256);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
    end
  endtask

  task automatic driveInputs(input ciOpcode_t opcode, input ciWord_t dataA, input ciWord_t dataB,
                             input logic start, input logic stall, input logic idle);
    ciN          = opcode;
    ciDataA      = dataA;
    ciDataB      = dataB;
    ciStart      = start;
    cpuIsStalled = stall;
    busIdle      = idle;
  endtask

  task automatic nextCycle();
    @(posedge s_systemClock);
    #1;
  endtask

  initial begin
    int          i;
    int          edgeIndex;
    int          base;
    ciWord_t     operand;
    logic [15:0] pixel;
    errorCount  = 0;
    checkCount  = 0;
    randomState = 32'he4593901;
    s_pllLocked = 1'b0;
    driveInputs(8'h00, '0, '0, 1'b0, 1'b0, 1'b0);
    $readmemh("ciPatterns.hex", patternMem);

    repeat (4) @(posedge s_systemClock);
    #1;
    // Camera held in reset while the PLL is unlocked
    checkValue("camnReset", 32'(camnReset), 32'd0);
    s_pllLocked = 1'b1;

    // Release on the 16th edge, profiling ignored before it
    for (edgeIndex = 1; edgeIndex <= 16; edgeIndex++) begin
      if (edgeIndex == 8) begin
        driveInputs(`CI_ID_PROFILE, '0, 32'h0000_000F, 1'b1, 1'b0, 1'b0);
      end
      @(negedge s_systemClock);
      checkValue("camnReset", 32'(camnReset), 32'd0);
      if (edgeIndex == 8) begin
        checkValue("ciDone", 32'(ciDone), 32'd0);
        checkValue("ciResult", ciResult, 32'd0);
      end
      nextCycle();
      driveInputs(8'h00, '0, '0, 1'b0, 1'b0, 1'b0);
    end
    @(negedge s_systemClock);
    checkValue("camnReset", 32'(camnReset), 32'd1);
    nextCycle();

    // One pattern line per cycle
    for (i = 0; i < patternCount; i++) begin
      base = i * patternWords;
      driveInputs(patternMem[base][7:0], patternMem[base+1], patternMem[base+2],
                  patternMem[base+3][0], patternMem[base+4][0], patternMem[base+5][0]);
      @(negedge s_systemClock);
      checkValue("ciDone", 32'(ciDone), patternMem[base+6]);
      checkValue("ciResult", ciResult, patternMem[base+7]);
      nextCycle();
    end

    // Swap and gray alternate; white and black pixels come first
    for (i = 0; i < randomCount; i++) begin
      randomState = nextRandom(randomState);
      if (i % 2 == 0) begin
        operand     = randomState;
        randomState = nextRandom(randomState);
        driveInputs(`CI_ID_SWAP, operand, {16'd0, randomState[31:16]}, 1'b1, 1'b0, 1'b0);
        @(negedge s_systemClock);
        checkValue("ciDone", 32'(ciDone), 32'd1);
        checkValue("ciResult", ciResult, expectedSwap(operand, randomState[16]));
      end else begin
        pixel = randomState[31:16];
        if (i == 1) begin
          pixel = 16'hFFFF;
        end else if (i == 3) begin
          pixel = 16'h0000;
        end
        driveInputs(`CI_ID_GRAY, {randomState[15:0], pixel}, randomState, 1'b1, 1'b0, 1'b0);
        @(negedge s_systemClock);
        checkValue("ciDone", 32'(ciDone), 32'd1);
        checkValue("ciResult", ciResult, expectedGray(pixel));
      end
      nextCycle();
    end

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: the run did not finish within %0d ns", timeoutNs);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- ciPatterns.hex
// Columns: ciN ciDataA ciDataB ciStart cpuIsStalled busIdle expectedDone expectedResult
// Counters: 0 total, 1 stall, 2 bus idle, 3 neither; reads give the value before the edge
0B 00000000 0000000F 1 0 0 1 00000000
00 00000000 00000000 0 1 0 0 00000000
00 00000000 00000000 0 1 0 0 00000000
00 00000000 00000000 0 0 1 0 00000000
00 00000000 00000000 0 0 1 0 00000000
00 00000000 00000000 0 0 1 0 00000000
00 00000000 00000000 0 0 0 0 00000000
00 00000000 00000000 0 1 1 0 00000000
0B 00000000 00000000 1 0 0 1 00000007
0B 00000001 00000000 1 0 0 1 00000003
0B 00000002 00000000 1 0 0 1 00000004
0B 00000003 00000000 1 0 0 1 00000004
0B 00000000 00000020 1 1 0 1 0000000B
00 00000000 00000000 0 1 0 0 00000000
00 00000000 00000000 0 1 0 0 00000000
0B 00000001 00000000 1 0 0 1 00000004
0B 00000002 00000400 1 0 1 1 00000004
0B 00000002 00000000 1 0 0 1 00000000
0B 00000003 00000180 1 0 0 1 00000007
00 00000000 00000000 0 0 1 0 00000000
0B 00000003 00000000 1 0 0 1 00000008
0B 00000000 00000000 1 0 0 1 00000002
0B 00000001 00000022 1 1 0 1 00000004
00 00000000 00000000 0 1 0 0 00000000
0B 00000001 00000000 1 0 0 1 00000005
7F 12345678 00000001 1 0 0 0 00000000
01 12345678 00000000 0 0 0 0 00000000
01 12345678 00000000 1 0 0 1 78563412

//--- all.f
+incdir+.
ciExtensionPkg.sv
resetSequencer.sv
swapByteIse.sv
grayscaleIse.sv
profileControl.sv
profileCounters.sv
customInstructionFabric.sv
tbCustomInstructionFabric.sv

//--- runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f \
  --top-module tbCustomInstructionFabric -o simTb > build.log 2>&1 &&
  ./obj_dir/simTb > sim.log 2>&1 ||
  { echo "Build or run failed, see build.log and sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }
